// File: common/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS   = 16;

    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0000;

    // major opcode field, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // OP_NOP also covers every unsupported encoding
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_EBREAK
    } op_e;

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import rv_core_pkg::*;
(
    input  logic            clock,
    input  logic            i_reset,
    output logic            o_imem_req,
    output logic [XLEN-1:0] o_imem_addr,
    input  logic            i_imem_ack,
    input  logic [XLEN-1:0] i_imem_data,
    input  logic            i_redirect,
    input  logic [XLEN-1:0] i_redirect_pc,
    input  logic            i_halted,
    output logic            o_fd_valid,
    input  logic            i_fd_ready,
    output logic [XLEN-1:0] o_fd_pc,
    output logic [XLEN-1:0] o_fd_instr
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            stale_q;
    logic            resp_take;
    logic            still_pending;
    logic            buf_load;
    logic            buf_drain;
    logic            buf_valid_next;
    logic            start_req;

    assign resp_take     = o_imem_req && i_imem_ack;
    assign still_pending = o_imem_req && !i_imem_ack;
    // responses overtaken by a redirect are dropped here
    assign buf_load      = resp_take && !stale_q && !i_redirect;
    assign buf_drain     = o_fd_valid && i_fd_ready;

    always_comb begin
        if (i_redirect) begin
            buf_valid_next = 1'b0;
        end else if (buf_load) begin
            buf_valid_next = 1'b1;
        end else if (buf_drain) begin
            buf_valid_next = 1'b0;
        end else begin
            buf_valid_next = o_fd_valid;
        end
    end

    always_comb begin
        if (i_redirect) begin
            pc_next = i_redirect_pc;
        end else if (buf_load) begin
            pc_next = o_imem_addr + XLEN'(4);
        end else begin
            pc_next = pc_q;
        end
    end

    // the response must find room in the buffer, so a new request goes out only
    // if the buffer ends up empty, or decode is idle and will take it next cycle
    assign start_req = !still_pending && !i_halted &&
                       (!buf_valid_next || (buf_load && !o_fd_valid && i_fd_ready));

    always_ff @(posedge clock) begin
        if (i_reset) begin
            o_imem_req <= 1'b0;
            o_fd_valid <= 1'b0;
            stale_q    <= 1'b0;
            pc_q       <= BOOT_PC;
        end else begin
            o_imem_req <= still_pending || start_req;
            o_fd_valid <= buf_valid_next;
            stale_q    <= still_pending && (stale_q || i_redirect);
            pc_q       <= pc_next;
        end
    end

    always_ff @(posedge clock) begin
        if (start_req) begin
            o_imem_addr <= pc_next;
        end
        if (buf_load) begin
            o_fd_pc    <= o_imem_addr;
            o_fd_instr <= i_imem_data;
        end
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import rv_core_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_reset,
    input  logic                  i_fd_valid,
    output logic                  o_fd_ready,
    input  logic [XLEN-1:0]       i_fd_pc,
    input  logic [XLEN-1:0]       i_fd_instr,
    input  logic                  i_redirect,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    input  logic [XLEN-1:0]       i_rs1_val,
    input  logic [XLEN-1:0]       i_rs2_val,
    input  logic                  i_rs1_busy,
    input  logic                  i_rs2_busy,
    input  logic                  i_rd_busy,
    output logic                  o_set_busy,
    output logic [REG_ADDR_W-1:0] o_set_busy_addr,
    output logic                  o_de_valid,
    output op_e                   o_de_op,
    output logic [XLEN-1:0]       o_de_pc,
    output logic [XLEN-1:0]       o_de_rs1_val,
    output logic [XLEN-1:0]       o_de_rs2_val,
    output logic [XLEN-1:0]       o_de_imm,
    output logic [REG_ADDR_W-1:0] o_de_rd
);

    logic            slot_valid;
    logic [XLEN-1:0] slot_pc;
    logic [XLEN-1:0] slot_instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    op_e             op;
    logic [XLEN-1:0] imm;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            writes_rd;
    logic            ctrl_in_exec;
    logic            stall;
    logic            issue;

    assign opcode = slot_instr[6:0];
    assign funct3 = slot_instr[14:12];
    assign funct7 = slot_instr[31:25];

    // RV32E, so only the low four bits of each register field
    assign o_rs1_addr      = slot_instr[18:15];
    assign o_rs2_addr      = slot_instr[23:20];
    assign o_set_busy_addr = slot_instr[10:7];

    always_comb begin
        op  = OP_NOP;
        imm = {{20{slot_instr[31]}}, slot_instr[31:20]};
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op = OP_ADD;
                        3'b001: op = OP_SLL;
                        3'b010: op = OP_SLT;
                        3'b100: op = OP_XOR;
                        3'b101: op = OP_SRL;
                        3'b110: op = OP_OR;
                        3'b111: op = OP_AND;
                        default: op = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = OP_SUB;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    default: op = OP_NOP;
                endcase
            end
            OPC_LUI: begin
                op  = OP_LUI;
                imm = {slot_instr[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = OP_BNE;
                end
                imm = {{19{slot_instr[31]}}, slot_instr[31], slot_instr[7],
                       slot_instr[30:25], slot_instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = {{11{slot_instr[31]}}, slot_instr[31], slot_instr[19:12],
                       slot_instr[20], slot_instr[30:21], 1'b0};
            end
            OPC_SYSTEM: begin
                if (slot_instr == 32'h0010_0073) begin
                    op = OP_EBREAK;
                end
            end
            default: op = OP_NOP;
        endcase
    end

    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_LUI, OP_JAL: writes_rd = 1'b1;
            OP_BEQ, OP_BNE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    // nothing younger enters execute until a branch or jump has resolved
    assign ctrl_in_exec = o_de_valid &&
                          (o_de_op == OP_BEQ || o_de_op == OP_BNE || o_de_op == OP_JAL);
    assign stall = (uses_rs1 && i_rs1_busy) || (uses_rs2 && i_rs2_busy) ||
                   (writes_rd && i_rd_busy) || ctrl_in_exec;
    assign issue      = slot_valid && !stall && !i_redirect;
    assign o_fd_ready = !slot_valid || issue;
    assign o_set_busy = issue && writes_rd;

    always_ff @(posedge clock) begin
        if (i_reset) begin
            slot_valid <= 1'b0;
            o_de_valid <= 1'b0;
        end else begin
            o_de_valid <= issue;
            if (i_redirect) begin
                slot_valid <= 1'b0;
            end else if (o_fd_ready) begin
                slot_valid <= i_fd_valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (o_fd_ready && i_fd_valid) begin
            slot_pc    <= i_fd_pc;
            slot_instr <= i_fd_instr;
        end
        if (issue) begin
            o_de_op      <= op;
            o_de_pc      <= slot_pc;
            o_de_rs1_val <= i_rs1_val;
            o_de_rs2_val <= i_rs2_val;
            o_de_imm     <= imm;
            o_de_rd      <= o_set_busy_addr;
        end
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file
    import rv_core_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_reset,
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    output logic [XLEN-1:0]       o_rs1_val,
    output logic [XLEN-1:0]       o_rs2_val,
    output logic                  o_rs1_busy,
    output logic                  o_rs2_busy,
    input  logic [REG_ADDR_W-1:0] i_rd_check_addr,
    output logic                  o_rd_busy,
    input  logic                  i_set_busy,
    input  logic [REG_ADDR_W-1:0] i_set_busy_addr,
    input  logic                  i_wen,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata
);

    // entry 0 is cleared by reset and never written
    logic [XLEN-1:0]     regs [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    assign o_rs1_val  = regs[i_rs1_addr];
    assign o_rs2_val  = regs[i_rs2_addr];
    assign o_rs1_busy = busy[i_rs1_addr];
    assign o_rs2_busy = busy[i_rs2_addr];
    assign o_rd_busy  = busy[i_rd_check_addr];

    always_ff @(posedge clock) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // scoreboard, a set in the same cycle as a clear wins
    always_ff @(posedge clock) begin
        if (i_reset) begin
            busy <= '0;
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin
                if (i_set_busy && i_set_busy_addr == REG_ADDR_W'(i)) begin
                    busy[i] <= 1'b1;
                end else if (i_wen && i_waddr == REG_ADDR_W'(i)) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import rv_core_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_reset,
    input  logic                  i_de_valid,
    input  op_e                   i_de_op,
    input  logic [XLEN-1:0]       i_de_pc,
    input  logic [XLEN-1:0]       i_de_rs1_val,
    input  logic [XLEN-1:0]       i_de_rs2_val,
    input  logic [XLEN-1:0]       i_de_imm,
    input  logic [REG_ADDR_W-1:0] i_de_rd,
    output logic                  o_wen,
    output logic [REG_ADDR_W-1:0] o_waddr,
    output logic [XLEN-1:0]       o_wdata,
    output logic                  o_redirect,
    output logic [XLEN-1:0]       o_redirect_pc,
    output logic                  o_retire_valid,
    output logic [XLEN-1:0]       o_retire_pc,
    output logic [REG_ADDR_W-1:0] o_retire_rd,
    output logic                  o_retire_wen,
    output logic [XLEN-1:0]       o_retire_wdata,
    output logic                  o_halted
);

    logic            accept;
    logic            halt_q;
    logic            taken;
    logic            writes;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] link_pc;

    // anything behind an EBREAK is ignored
    assign accept  = i_de_valid && !halt_q;
    assign link_pc = i_de_pc + XLEN'(4);

    always_comb begin
        result = '0;
        writes = 1'b1;
        taken  = 1'b0;
        case (i_de_op)
            OP_ADD:  result = i_de_rs1_val + i_de_rs2_val;
            OP_SUB:  result = i_de_rs1_val - i_de_rs2_val;
            OP_AND:  result = i_de_rs1_val & i_de_rs2_val;
            OP_OR:   result = i_de_rs1_val | i_de_rs2_val;
            OP_XOR:  result = i_de_rs1_val ^ i_de_rs2_val;
            OP_SLT:  result = XLEN'($signed(i_de_rs1_val) < $signed(i_de_rs2_val));
            OP_SLL:  result = i_de_rs1_val << i_de_rs2_val[4:0];
            OP_SRL:  result = i_de_rs1_val >> i_de_rs2_val[4:0];
            OP_ADDI: result = i_de_rs1_val + i_de_imm;
            OP_ANDI: result = i_de_rs1_val & i_de_imm;
            OP_ORI:  result = i_de_rs1_val | i_de_imm;
            OP_XORI: result = i_de_rs1_val ^ i_de_imm;
            OP_LUI:  result = i_de_imm;
            OP_JAL: begin
                result = link_pc;
                taken  = 1'b1;
            end
            OP_BEQ: begin
                writes = 1'b0;
                taken  = (i_de_rs1_val == i_de_rs2_val);
            end
            OP_BNE: begin
                writes = 1'b0;
                taken  = (i_de_rs1_val != i_de_rs2_val);
            end
            default: writes = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (i_reset) begin
            o_retire_valid <= 1'b0;
            o_wen          <= 1'b0;
            o_redirect     <= 1'b0;
            halt_q         <= 1'b0;
            o_halted       <= 1'b0;
        end else begin
            o_retire_valid <= accept;
            o_wen          <= accept && writes && (i_de_rd != '0);
            o_redirect     <= accept && taken;
            halt_q         <= halt_q || (accept && i_de_op == OP_EBREAK);
            // visible one cycle after the EBREAK retires
            o_halted       <= halt_q;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            o_waddr       <= i_de_rd;
            o_wdata       <= result;
            o_retire_pc   <= i_de_pc;
            o_redirect_pc <= i_de_pc + i_de_imm;
        end
    end

    // retire record is the writeback itself
    assign o_retire_rd    = o_waddr;
    assign o_retire_wen   = o_wen;
    assign o_retire_wdata = o_wdata;

endmodule

// File: rtl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_reset,
    output logic                  o_imem_req,
    output logic [XLEN-1:0]       o_imem_addr,
    input  logic                  i_imem_ack,
    input  logic [XLEN-1:0]       i_imem_data,
    output logic                  o_retire_valid,
    output logic [XLEN-1:0]       o_retire_pc,
    output logic [REG_ADDR_W-1:0] o_retire_rd,
    output logic                  o_retire_wen,
    output logic [XLEN-1:0]       o_retire_wdata,
    output logic                  o_halted
);

    logic                  fd_valid;
    logic                  fd_ready;
    logic [XLEN-1:0]       fd_pc;
    logic [XLEN-1:0]       fd_instr;
    logic                  de_valid;
    op_e                   de_op;
    logic [XLEN-1:0]       de_pc;
    logic [XLEN-1:0]       de_rs1_val;
    logic [XLEN-1:0]       de_rs2_val;
    logic [XLEN-1:0]       de_imm;
    logic [REG_ADDR_W-1:0] de_rd;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic                  rs1_busy;
    logic                  rs2_busy;
    logic                  rd_busy;
    logic                  set_busy;
    logic [REG_ADDR_W-1:0] set_busy_addr;
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;

    fetch_stage fetch_i (
        .clock          (clock),
        .i_reset        (i_reset),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .i_imem_ack     (i_imem_ack),
        .i_imem_data    (i_imem_data),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .i_halted       (o_halted),
        .o_fd_valid     (fd_valid),
        .i_fd_ready     (fd_ready),
        .o_fd_pc        (fd_pc),
        .o_fd_instr     (fd_instr)
    );

    decode_stage decode_i (
        .clock           (clock),
        .i_reset         (i_reset),
        .i_fd_valid      (fd_valid),
        .o_fd_ready      (fd_ready),
        .i_fd_pc         (fd_pc),
        .i_fd_instr      (fd_instr),
        .i_redirect      (redirect),
        .o_rs1_addr      (rs1_addr),
        .o_rs2_addr      (rs2_addr),
        .i_rs1_val       (rs1_val),
        .i_rs2_val       (rs2_val),
        .i_rs1_busy      (rs1_busy),
        .i_rs2_busy      (rs2_busy),
        .i_rd_busy       (rd_busy),
        .o_set_busy      (set_busy),
        .o_set_busy_addr (set_busy_addr),
        .o_de_valid      (de_valid),
        .o_de_op         (de_op),
        .o_de_pc         (de_pc),
        .o_de_rs1_val    (de_rs1_val),
        .o_de_rs2_val    (de_rs2_val),
        .o_de_imm        (de_imm),
        .o_de_rd         (de_rd)
    );

    // rd field doubles as the busy check address
    register_file regfile_i (
        .clock           (clock),
        .i_reset         (i_reset),
        .i_rs1_addr      (rs1_addr),
        .i_rs2_addr      (rs2_addr),
        .o_rs1_val       (rs1_val),
        .o_rs2_val       (rs2_val),
        .o_rs1_busy      (rs1_busy),
        .o_rs2_busy      (rs2_busy),
        .i_rd_check_addr (set_busy_addr),
        .o_rd_busy       (rd_busy),
        .i_set_busy      (set_busy),
        .i_set_busy_addr (set_busy_addr),
        .i_wen           (wen),
        .i_waddr         (waddr),
        .i_wdata         (wdata)
    );

    execute_stage execute_i (
        .clock          (clock),
        .i_reset        (i_reset),
        .i_de_valid     (de_valid),
        .i_de_op        (de_op),
        .i_de_pc        (de_pc),
        .i_de_rs1_val   (de_rs1_val),
        .i_de_rs2_val   (de_rs2_val),
        .i_de_imm       (de_imm),
        .i_de_rd        (de_rd),
        .o_wen          (wen),
        .o_waddr        (waddr),
        .o_wdata        (wdata),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc),
        .o_retire_rd    (o_retire_rd),
        .o_retire_wen   (o_retire_wen),
        .o_retire_wdata (o_retire_wdata),
        .o_halted       (o_halted)
    );

endmodule

// File: tests/imem_model.sv
`timescale 1ns/1ps

module imem_model
    import rv_core_pkg::*;
(
    input  logic            clock,
    input  logic            i_reset,
    input  logic            i_req,
    input  logic [XLEN-1:0] i_addr,
    output logic            o_ack,
    output logic [XLEN-1:0] o_data
);

    localparam int DEPTH = 256;

    logic [XLEN-1:0] mem [DEPTH];
    integer          seed = 32'h2475;
    logic            waiting;
    int unsigned     wait_left;

    initial begin
        o_ack  = 1'b0;
        o_data = '0;
    end

    // one ack per request, after 0 to 3 idle cycles
    always @(posedge clock) begin : respond
        int unsigned delay;
        if (i_reset) begin
            o_ack     <= 1'b0;
            waiting   <= 1'b0;
            wait_left <= 0;
        end else if (o_ack) begin
            o_ack <= 1'b0;
        end else if (i_req && !waiting) begin
            delay = $unsigned($random(seed)) % 4;
            if (delay == 0) begin
                o_ack  <= 1'b1;
                o_data <= mem[(i_addr >> 2) % DEPTH];
            end else begin
                waiting   <= 1'b1;
                wait_left <= delay;
            end
        end else if (waiting) begin
            if (wait_left == 1) begin
                o_ack   <= 1'b1;
                o_data  <= mem[(i_addr >> 2) % DEPTH];
                waiting <= 1'b0;
            end
            wait_left <= wait_left - 1;
        end
    end

endmodule

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
    import rv_core_pkg::*;
();

    // program words of all tests together
    localparam int TOTAL_INSTR = 50;
    localparam int HALT_WINDOW = 16;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic                  clock;
    logic                  i_reset;
    logic                  imem_req;
    logic [XLEN-1:0]       imem_addr;
    logic                  imem_ack;
    logic [XLEN-1:0]       imem_data;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic                  retire_wen;
    logic [XLEN-1:0]       retire_wdata;
    logic                  halted;

    string       test_name;
    logic [31:0] exp_pc[$];
    int          exp_rd[$];
    bit          exp_wen[$];
    logic [31:0] exp_data[$];

    rv_core_top dut_i (
        .clock          (clock),
        .i_reset        (i_reset),
        .o_imem_req     (imem_req),
        .o_imem_addr    (imem_addr),
        .i_imem_ack     (imem_ack),
        .i_imem_data    (imem_data),
        .o_retire_valid (retire_valid),
        .o_retire_pc    (retire_pc),
        .o_retire_rd    (retire_rd),
        .o_retire_wen   (retire_wen),
        .o_retire_wdata (retire_wdata),
        .o_halted       (halted)
    );

    imem_model imem_i (
        .clock   (clock),
        .i_reset (i_reset),
        .i_req   (imem_req),
        .i_addr  (imem_addr),
        .o_ack   (imem_ack),
        .o_data  (imem_data)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        repeat (TOTAL_INSTR * 20) @(posedge clock);
        $display("timeout, the core stopped retiring in test %s", test_name);
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd,
                                           input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), OPC_LUI};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input logic [12:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OPC_JAL};
    endfunction

    // holds the core in reset and refills memory with addi x0 words
    task automatic begin_test(input string name);
        test_name = name;
        exp_pc.delete();
        exp_rd.delete();
        exp_wen.delete();
        exp_data.delete();
        @(posedge clock);
        i_reset <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem_i.mem[i] = i_type(3'b000, 0, 0, 12'(i));
        end
    endtask

    task automatic put_instr(input int pc, input logic [31:0] word);
        imem_i.mem[pc / 4] = word;
    endtask

    // rd of -1 means the record has no destination to compare
    task automatic expect_retire(input int pc, input int rd, input bit wen,
                                 input logic [31:0] data);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_wen.push_back(wen);
        exp_data.push_back(data);
    endtask

    task automatic run_program();
        int n;
        bit prev_req;
        repeat (4) @(posedge clock);
        i_reset <= 1'b0;
        @(negedge clock);
        check("request in first cycle", 0, imem_req);
        while (!imem_req) begin
            check("retire valid after reset", 0, retire_valid);
            check("halted after reset", 0, halted);
            @(negedge clock);
        end
        check("first request address", BOOT_PC, imem_addr);
        n = 0;
        while (n < exp_pc.size()) begin
            @(negedge clock);
            check("halted before ebreak", 0, halted);
            if (retire_valid) begin
                check("retire pc", exp_pc[n], retire_pc);
                check("retire wen", exp_wen[n], retire_wen);
                if (exp_rd[n] >= 0) begin
                    check("retire rd", exp_rd[n], retire_rd);
                end
                if (exp_wen[n]) begin
                    check("retire data", exp_data[n], retire_wdata);
                end
                n++;
            end
        end
        // halt shows one cycle after the ebreak record
        @(negedge clock);
        check("halted after ebreak", 1, halted);
        check("retire valid after ebreak", 0, retire_valid);
        prev_req = imem_req;
        repeat (HALT_WINDOW) begin
            @(negedge clock);
            check("retire valid while halted", 0, retire_valid);
            check("halted held", 1, halted);
            if (imem_req && !prev_req) begin
                $display("a new fetch request started while halted in test %s", test_name);
                stop_with_failure();
            end
            prev_req = imem_req;
        end
    endtask

    task automatic test_alu();
        begin_test("alu");
        put_instr(0,  i_type(3'b000, 1, 0, 12'd12));
        put_instr(4,  i_type(3'b000, 2, 0, 12'hffa));
        put_instr(8,  r_type(7'h00, 3'b000, 3, 1, 2));
        put_instr(12, r_type(7'h20, 3'b000, 4, 1, 2));
        put_instr(16, r_type(7'h00, 3'b111, 5, 1, 2));
        put_instr(20, r_type(7'h00, 3'b110, 6, 1, 2));
        put_instr(24, r_type(7'h00, 3'b100, 7, 1, 2));
        put_instr(28, r_type(7'h00, 3'b010, 8, 1, 2));
        put_instr(32, r_type(7'h00, 3'b010, 9, 2, 1));
        put_instr(36, r_type(7'h00, 3'b001, 10, 1, 3));
        put_instr(40, r_type(7'h00, 3'b101, 11, 2, 3));
        put_instr(44, i_type(3'b111, 12, 2, 12'h0f0));
        put_instr(48, i_type(3'b110, 13, 1, 12'h701));
        put_instr(52, i_type(3'b100, 14, 1, 12'hfff));
        put_instr(56, lui_word(15, 20'habcde));
        put_instr(60, EBREAK_WORD);
        expect_retire(0,  1,  1, 32'h0000_000c);
        expect_retire(4,  2,  1, 32'hffff_fffa);
        expect_retire(8,  3,  1, 32'h0000_0006);
        expect_retire(12, 4,  1, 32'h0000_0012);
        expect_retire(16, 5,  1, 32'h0000_0008);
        expect_retire(20, 6,  1, 32'hffff_fffe);
        expect_retire(24, 7,  1, 32'hffff_fff6);
        expect_retire(28, 8,  1, 32'h0000_0000);
        expect_retire(32, 9,  1, 32'h0000_0001);
        expect_retire(36, 10, 1, 32'h0000_0300);
        expect_retire(40, 11, 1, 32'h03ff_ffff);
        expect_retire(44, 12, 1, 32'h0000_00f0);
        expect_retire(48, 13, 1, 32'h0000_070d);
        expect_retire(52, 14, 1, 32'hffff_fff3);
        expect_retire(56, 15, 1, 32'habcd_e000);
        expect_retire(60, -1, 0, 32'h0);
        run_program();
    endtask

    // each instruction reads the result of the one before
    task automatic test_chain();
        begin_test("chain");
        put_instr(0,  i_type(3'b000, 1, 0, 12'd1));
        put_instr(4,  r_type(7'h00, 3'b000, 2, 1, 1));
        put_instr(8,  r_type(7'h00, 3'b000, 3, 2, 1));
        put_instr(12, r_type(7'h00, 3'b000, 4, 3, 3));
        put_instr(16, r_type(7'h00, 3'b100, 5, 4, 3));
        put_instr(20, i_type(3'b000, 5, 5, 12'd100));
        put_instr(24, r_type(7'h00, 3'b001, 6, 5, 1));
        put_instr(28, r_type(7'h00, 3'b101, 7, 6, 2));
        put_instr(32, r_type(7'h00, 3'b110, 1, 7, 6));
        put_instr(36, r_type(7'h00, 3'b000, 1, 1, 1));
        put_instr(40, EBREAK_WORD);
        expect_retire(0,  1, 1, 32'h0000_0001);
        expect_retire(4,  2, 1, 32'h0000_0002);
        expect_retire(8,  3, 1, 32'h0000_0003);
        expect_retire(12, 4, 1, 32'h0000_0006);
        expect_retire(16, 5, 1, 32'h0000_0005);
        expect_retire(20, 5, 1, 32'h0000_0069);
        expect_retire(24, 6, 1, 32'h0000_00d2);
        expect_retire(28, 7, 1, 32'h0000_0034);
        expect_retire(32, 1, 1, 32'h0000_00f6);
        expect_retire(36, 1, 1, 32'h0000_01ec);
        expect_retire(40, -1, 0, 32'h0);
        run_program();
    endtask

    task automatic test_control();
        begin_test("control");
        put_instr(0,  i_type(3'b000, 1, 0, 12'd7));
        put_instr(4,  i_type(3'b000, 2, 0, 12'd7));
        put_instr(8,  branch_word(3'b000, 1, 2, 13'd12));
        put_instr(12, i_type(3'b000, 3, 0, 12'd1));
        put_instr(16, i_type(3'b000, 3, 0, 12'd2));
        put_instr(20, branch_word(3'b001, 1, 2, 13'd8));
        put_instr(24, i_type(3'b000, 4, 0, 12'd3));
        put_instr(28, jal_word(5, 21'd12));
        put_instr(32, i_type(3'b000, 6, 0, 12'd1));
        put_instr(36, i_type(3'b000, 6, 0, 12'd2));
        put_instr(40, r_type(7'h00, 3'b000, 7, 5, 4));
        put_instr(44, EBREAK_WORD);
        expect_retire(0,  1,  1, 32'h0000_0007);
        expect_retire(4,  2,  1, 32'h0000_0007);
        expect_retire(8,  -1, 0, 32'h0);
        expect_retire(20, -1, 0, 32'h0);
        expect_retire(24, 4,  1, 32'h0000_0003);
        expect_retire(28, 5,  1, 32'h0000_0020);
        expect_retire(40, 7,  1, 32'h0000_0023);
        expect_retire(44, -1, 0, 32'h0);
        run_program();
    endtask

    task automatic test_reg0();
        begin_test("reg0");
        put_instr(0,  i_type(3'b000, 0, 0, 12'd55));
        put_instr(4,  i_type(3'b000, 1, 0, 12'd9));
        put_instr(8,  r_type(7'h00, 3'b000, 0, 1, 1));
        put_instr(12, r_type(7'h00, 3'b000, 2, 0, 1));
        put_instr(16, lui_word(0, 20'h12345));
        put_instr(20, i_type(3'b110, 3, 0, 12'h0a5));
        put_instr(24, EBREAK_WORD);
        expect_retire(0,  0,  0, 32'h0);
        expect_retire(4,  1,  1, 32'h0000_0009);
        expect_retire(8,  0,  0, 32'h0);
        expect_retire(12, 2,  1, 32'h0000_0009);
        expect_retire(16, 0,  0, 32'h0);
        expect_retire(20, 3,  1, 32'h0000_00a5);
        expect_retire(24, -1, 0, 32'h0);
        run_program();
    endtask

    // words after the ebreak must never retire
    task automatic test_halt();
        begin_test("halt");
        put_instr(0,  i_type(3'b000, 1, 0, 12'd1));
        put_instr(4,  EBREAK_WORD);
        put_instr(8,  i_type(3'b000, 2, 0, 12'd2));
        put_instr(12, i_type(3'b000, 3, 0, 12'd3));
        expect_retire(0, 1,  1, 32'h0000_0001);
        expect_retire(4, -1, 0, 32'h0);
        run_program();
    endtask

    initial begin
        i_reset   = 1'b1;
        test_name = "reset";
        test_alu();
        test_chain();
        test_control();
        test_reg0();
        test_halt();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verilog.f
common/rv_core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/rv_core_top.sv
tests/imem_model.sv
tests/tb_rv_core.sv
